/* chan.f */
+incdir+.
chan_cfg_pkg.sv
chan_data_pkg.sv
chan_cfg_if.sv
chan_settings.sv
chan_pfb_filter.sv
chan_packetizer.sv
chan_top.sv
chan_chk.sv
chan_tb.sv

/* chan_cfg_if.sv */
/*
 * Configuration and coefficient write link from the
 * settings bank to the filter and the packetizer
 */
`timescale 1ns/1ps

interface chan_cfg_if;

  // Channel count as log2, already clamped
  chan_cfg_pkg::fft_log2_t  fft_log2;
  // Packet size, never 0
  chan_cfg_pkg::pkt_len_t   pkt_len;
  // One-cycle coefficient write
  logic                     coef_stb;
  chan_cfg_pkg::coef_addr_t coef_addr;
  chan_data_pkg::coef_t     coef_data;

  // Settings bank drives everything
  modport ctrl (output fft_log2, pkt_len, coef_stb, coef_addr, coef_data);
  // Filter needs the channel count and coefficient writes
  modport filt (input fft_log2, coef_stb, coef_addr, coef_data);
  // Packetizer needs the packet size only
  modport pack (input pkt_len);

endinterface

/* chan_cfg_pkg.sv */
/*
 * Control plane types: settings bus address and data,
 * readback data, channel count, packet size, coefficient address
 */
package chan_cfg_pkg;

  //////////////////////////////
  // Settings bus
  //////////////////////////////
  // Register address on the strobed bus
  typedef logic [7:0]  set_addr_t;
  // Write data, only the low bits matter for most registers
  typedef logic [31:0] set_data_t;
  // Registered readback word
  typedef logic [31:0] rb_data_t;

  //////////////////////////////
  // Configuration values
  //////////////////////////////
  // Channel count M = 2**fft_log2, 0 to 4
  typedef logic [2:0]  fft_log2_t;
  // Outputs per packet, 0 is never stored
  typedef logic [15:0] pkt_len_t;
  // Linear coefficient address
  // Tap k of branch b sits at k*M + b
  typedef logic [5:0]  coef_addr_t;

endpackage

/* chan_chk.sv */
/*
 * Concurrent checks bound into the filter bank and the packetizer
 */
`timescale 1ns/1ps

module chan_chk #(
  parameter bit FILTER_SIDE = 1'b1
) (
  input logic                   ce_clk,
  input logic                   i_rst_n,
  input logic                   i_stb,
  input logic                   i_out_stb,
  input logic                   i_last,
  input chan_data_pkg::branch_t i_branch,
  input chan_data_pkg::branch_t i_br_mask
);

  // Async reset holds the strobe low
  a_no_stb_in_reset: assert property (@(posedge ce_clk) !i_rst_n |-> !i_out_stb)
    else $error("output strobe seen during reset");

  if (FILTER_SIDE) begin : g_filt
    // Three pipeline stages from sample to sum
    a_latency: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
      i_stb |-> ##3 i_out_stb)
      else $error("filter strobe missing three cycles after input");
    // Commutator never points past M-1
    a_branch: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
      i_branch <= i_br_mask)
      else $error("branch index outside channel count");
  end else begin : g_pack
    a_last: assert property (@(posedge ce_clk) disable iff (!i_rst_n) i_last |-> i_out_stb)
      else $error("last flag without output strobe");
  end

endmodule

bind chan_pfb_filter chan_chk #(.FILTER_SIDE(1'b1)) u_chk (
  .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_stb(i_in_stb), .i_out_stb(o_f_stb),
  .i_last(1'b0), .i_branch(br_cur), .i_br_mask(br_mask));

bind chan_packetizer chan_chk #(.FILTER_SIDE(1'b0)) u_chk (
  .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_stb(i_f_stb), .i_out_stb(o_out_stb),
  .i_last(o_out_last), .i_branch(4'd0), .i_br_mask(4'hf));

/* chan_data_pkg.sv */
/*
 * Datapath types: samples, coefficients, products,
 * tap sums and branch index
 */
package chan_data_pkg;

  //////////////////////////////
  // Filter operands
  //////////////////////////////
  // Real input sample
  typedef logic signed [15:0] sample_t;
  // One tap weight
  typedef logic signed [15:0] coef_t;

  //////////////////////////////
  // Filter results
  //////////////////////////////
  // Full precision 16x16 product
  typedef logic signed [31:0] prod_t;
  // Sum of four products
  // Two guard bits so no tap sum can overflow
  typedef logic signed [33:0] acc_t;

  //////////////////////////////
  // Commutator
  //////////////////////////////
  // Branch index, up to 16 branches
  typedef logic [3:0] branch_t;

endpackage

/* chan_defs.svh */
/*
 * Settings bus write and readback addresses, tap count,
 * channel count limit and register reset values
 */
`ifndef CHAN_DEFS_SVH
`define CHAN_DEFS_SVH

//////////////////////////////
// Settings write addresses
//////////////////////////////
// Channel count as log2
`define CHAN_SR_FFT_SIZE     129
// Coefficient write, pointer advances
`define CHAN_SR_RELOAD       131
// Coefficient write, pointer back to 0
`define CHAN_SR_RELOAD_LAST  132
// Outputs per packet
`define CHAN_SR_PKT_SIZE     133

//////////////////////////////
// Readback addresses
//////////////////////////////
`define CHAN_RB_NUM_TAPS     128
`define CHAN_RB_FFT_SIZE     129
`define CHAN_RB_PKT_SIZE     133
`define CHAN_RB_COEF_PTR     134
// Returned for any address not decoded
`define CHAN_RB_BAD          32'h0BADC0DE

//////////////////////////////
// Filter bank limits
//////////////////////////////
`define CHAN_TAPS            4
`define CHAN_MAX_LOG2        4
`define CHAN_PKT_RESET       16

`endif

/* chan_packetizer.sv */
/*
 * Output register stage and packet framing with last flag
 */
`timescale 1ns/1ps
`include "chan_defs.svh"

module chan_packetizer (
  input  logic                    ce_clk,
  input  logic                    i_rst_n,
  chan_cfg_if.pack                i_cfg,
  input  logic                    i_f_stb,
  input  chan_data_pkg::acc_t     i_f_sum,
  input  chan_data_pkg::branch_t  i_f_branch,
  output logic                    o_out_stb,
  output chan_data_pkg::acc_t     o_out_data,
  output chan_data_pkg::branch_t  o_out_chan,
  output logic                    o_out_last
);

  // Outputs already sent in the current packet
  chan_cfg_pkg::pkt_len_t out_cnt;
  logic                   pkt_end;

  // Also true when the size shrank below the count,
  // so an oversized packet closes at the next output
  assign pkt_end = (out_cnt + 1'b1) >= i_cfg.pkt_len;

  //////////////////////////////
  // Framing
  //////////////////////////////
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_cnt    <= '0;
      o_out_stb  <= 1'b0;
      o_out_last <= 1'b0;
    end else begin
      o_out_stb  <= i_f_stb;
      // Last only ever rides on a strobe
      o_out_last <= i_f_stb && pkt_end;
      if (i_f_stb) begin
        out_cnt <= pkt_end ? '0 : out_cnt + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge ce_clk) begin
    if (i_f_stb) begin
      o_out_data <= i_f_sum;
      o_out_chan <= i_f_branch;
    end
  end

endmodule

/* chan_pfb_filter.sv */
/*
 * Polyphase filter bank: commutator, per-branch history,
 * coefficient store and three-stage multiply-accumulate
 */
`timescale 1ns/1ps
`include "chan_defs.svh"

module chan_pfb_filter (
  input  logic                    ce_clk,
  input  logic                    i_rst_n,
  chan_cfg_if.filt                i_cfg,
  input  logic                    i_in_stb,
  input  chan_data_pkg::sample_t  i_in_data,
  output logic                    o_f_stb,
  output chan_data_pkg::acc_t     o_f_sum,
  output chan_data_pkg::branch_t  o_f_branch
);

  localparam int unsigned TAPS   = `CHAN_TAPS;
  localparam int unsigned NUM_BR = 1 << `CHAN_MAX_LOG2;

  // Indexed [tap][branch]
  chan_data_pkg::coef_t    coef_mem [TAPS][NUM_BR];
  // Indexed [branch][age], age 0 is the newest sample
  chan_data_pkg::sample_t  hist_mem [NUM_BR][TAPS];

  chan_data_pkg::branch_t  br_mask;
  chan_cfg_pkg::coef_addr_t wr_tap;
  chan_data_pkg::branch_t  wr_branch;
  chan_cfg_pkg::fft_log2_t fft_prev;
  chan_data_pkg::branch_t  br_cnt;
  chan_data_pkg::branch_t  br_cur;

  logic                    s1_vld;
  chan_data_pkg::sample_t  s1_hist [TAPS];
  chan_data_pkg::coef_t    s1_coef [TAPS];
  chan_data_pkg::branch_t  s1_branch;
  logic                    s2_vld;
  chan_data_pkg::prod_t    s2_prod [TAPS];
  chan_data_pkg::branch_t  s2_branch;
  chan_data_pkg::acc_t     sum_c;

  // M-1, used both as wrap point and as address mask
  assign br_mask = chan_data_pkg::branch_t'((5'd1 << i_cfg.fft_log2) - 5'd1);

  //////////////////////////////
  // Coefficient store
  //////////////////////////////
  // Linear address k*M + b splits into tap k and branch b
  assign wr_tap    = i_cfg.coef_addr >> i_cfg.fft_log2;
  assign wr_branch = chan_data_pkg::branch_t'(i_cfg.coef_addr) & br_mask;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < TAPS; k++) begin
        for (int b = 0; b < NUM_BR; b++) begin
          coef_mem[k][b] <= '0;
        end
      end
    end else if (i_cfg.coef_stb && (wr_tap < TAPS)) begin
      // Addresses past the last tap for small M are dropped
      coef_mem[wr_tap[1:0]][wr_branch] <= i_cfg.coef_data;
    end
  end

  //////////////////////////////
  // Commutator
  //////////////////////////////
  // A new channel count restarts at branch 0 in the same cycle
  assign br_cur = (i_cfg.fft_log2 != fft_prev) ? '0 : br_cnt;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fft_prev <= '0;
      br_cnt   <= '0;
    end else begin
      fft_prev <= i_cfg.fft_log2;
      if (i_in_stb) begin
        br_cnt <= (br_cur == br_mask) ? '0 : br_cur + 1'b1;
      end else begin
        br_cnt <= br_cur;
      end
    end
  end

  // Branch history shifts only when its branch takes a sample
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int b = 0; b < NUM_BR; b++) begin
        for (int k = 0; k < TAPS; k++) begin
          hist_mem[b][k] <= '0;
        end
      end
    end else if (i_in_stb) begin
      hist_mem[br_cur][0] <= i_in_data;
      for (int k = 1; k < TAPS; k++) begin
        hist_mem[br_cur][k] <= hist_mem[br_cur][k-1];
      end
    end
  end

  //////////////////////////////
  // MAC pipeline
  //////////////////////////////
  // Valid bits walk down the pipe, one per stage
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_vld  <= 1'b0;
      s2_vld  <= 1'b0;
      o_f_stb <= 1'b0;
    end else begin
      s1_vld  <= i_in_stb;
      s2_vld  <= s1_vld;
      o_f_stb <= s2_vld;
    end
  end

  // Stage 1 latches the shifted history and the branch's taps
  always_ff @(posedge ce_clk) begin
    s1_hist[0] <= i_in_data;
    for (int k = 1; k < TAPS; k++) begin
      s1_hist[k] <= hist_mem[br_cur][k-1];
    end
    for (int k = 0; k < TAPS; k++) begin
      s1_coef[k] <= coef_mem[k][br_cur];
    end
    s1_branch <= br_cur;
  end

  // Stage 2, all four multipliers in parallel
  always_ff @(posedge ce_clk) begin
    for (int k = 0; k < TAPS; k++) begin
      s2_prod[k] <= s1_hist[k] * s1_coef[k];
    end
    s2_branch <= s1_branch;
  end

  // Adder tree, sign extended into the wider sum
  always_comb begin
    sum_c = '0;
    for (int k = 0; k < TAPS; k++) begin
      sum_c = sum_c + chan_data_pkg::acc_t'(s2_prod[k]);
    end
  end

  // Stage 3 registers the sum with its branch
  always_ff @(posedge ce_clk) begin
    o_f_sum    <= sum_c;
    o_f_branch <= s2_branch;
  end

endmodule

/* chan_settings.sv */
/*
 * Settings register bank: fft_log2, packet size and coefficient
 * reload pointer, coefficient write strobe, registered readback
 */
`timescale 1ns/1ps
`include "chan_defs.svh"

module chan_settings (
  input  logic                      ce_clk,
  input  logic                      i_rst_n,
  input  logic                      i_set_stb,
  input  chan_cfg_pkg::set_addr_t   i_set_addr,
  input  chan_cfg_pkg::set_data_t   i_set_data,
  input  chan_cfg_pkg::set_addr_t   i_rb_addr,
  output chan_cfg_pkg::rb_data_t    o_rb_data,
  chan_cfg_if.ctrl                  o_cfg
);

  chan_cfg_pkg::fft_log2_t  fft_log2;
  chan_cfg_pkg::pkt_len_t   pkt_len;
  chan_cfg_pkg::coef_addr_t coef_ptr;
  logic                     coef_stb;
  chan_cfg_pkg::coef_addr_t coef_addr;
  chan_data_pkg::coef_t     coef_data;
  logic                     reload_hit;
  chan_cfg_pkg::rb_data_t   rb_next;

  // Either reload address writes a coefficient
  assign reload_hit = i_set_stb &&
                      ((i_set_addr == `CHAN_SR_RELOAD) ||
                       (i_set_addr == `CHAN_SR_RELOAD_LAST));

  //////////////////////////////
  // Register writes
  //////////////////////////////
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      // Eight channels out of reset
      fft_log2 <= chan_cfg_pkg::fft_log2_t'(3);
      pkt_len  <= chan_cfg_pkg::pkt_len_t'(`CHAN_PKT_RESET);
      coef_ptr <= '0;
      coef_stb <= 1'b0;
    end else begin
      // Strobe lasts a single cycle
      coef_stb <= reload_hit;
      if (i_set_stb) begin
        case (i_set_addr)
          `CHAN_SR_FFT_SIZE: begin
            // Anything above the limit saturates
            if (i_set_data > `CHAN_MAX_LOG2) begin
              fft_log2 <= chan_cfg_pkg::fft_log2_t'(`CHAN_MAX_LOG2);
            end else begin
              fft_log2 <= i_set_data[2:0];
            end
          end
          `CHAN_SR_PKT_SIZE: begin
            // Zero length packets make no sense, keep old size
            if (i_set_data[15:0] != '0) begin
              pkt_len <= i_set_data[15:0];
            end
          end
          `CHAN_SR_RELOAD: coef_ptr <= coef_ptr + 1'b1;
          `CHAN_SR_RELOAD_LAST: coef_ptr <= '0;
          default: ;
        endcase
      end
    end
  end

  // Coefficient payload goes out with the pointer before it moves
  always_ff @(posedge ce_clk) begin
    if (reload_hit) begin
      coef_addr <= coef_ptr;
      coef_data <= $signed(i_set_data[15:0]);
    end
  end

  assign o_cfg.fft_log2  = fft_log2;
  assign o_cfg.pkt_len   = pkt_len;
  assign o_cfg.coef_stb  = coef_stb;
  assign o_cfg.coef_addr = coef_addr;
  assign o_cfg.coef_data = coef_data;

  //////////////////////////////
  // Readback
  //////////////////////////////
  always_comb begin
    case (i_rb_addr)
      // Total taps is M branches times taps per branch
      `CHAN_RB_NUM_TAPS: rb_next = chan_cfg_pkg::rb_data_t'(`CHAN_TAPS) << fft_log2;
      `CHAN_RB_FFT_SIZE: rb_next = chan_cfg_pkg::rb_data_t'(fft_log2);
      `CHAN_RB_PKT_SIZE: rb_next = chan_cfg_pkg::rb_data_t'(pkt_len);
      `CHAN_RB_COEF_PTR: rb_next = chan_cfg_pkg::rb_data_t'(coef_ptr);
      default:           rb_next = `CHAN_RB_BAD;
    endcase
  end

  // No read strobe, the word follows the address one cycle later
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rb_data <= '0;
    end else begin
      o_rb_data <= rb_next;
    end
  end

endmodule

/* chan_tb.sv */
/*
 * Testbench for the channelizer compute engine: clock, reset,
 * settings and sample stimulus, reference model, compare process
 */
`timescale 1ns/1ps
`include "chan_defs.svh"

module chan_tb;

  // About ten times the roughly 1500 stimulus cycles
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int TAPS = `CHAN_TAPS;
  localparam chan_cfg_pkg::set_addr_t A_FFT   = chan_cfg_pkg::set_addr_t'(`CHAN_SR_FFT_SIZE);
  localparam chan_cfg_pkg::set_addr_t A_RLD   = chan_cfg_pkg::set_addr_t'(`CHAN_SR_RELOAD);
  localparam chan_cfg_pkg::set_addr_t A_RLDL  = chan_cfg_pkg::set_addr_t'(`CHAN_SR_RELOAD_LAST);
  localparam chan_cfg_pkg::set_addr_t A_PKT   = chan_cfg_pkg::set_addr_t'(`CHAN_SR_PKT_SIZE);
  localparam chan_cfg_pkg::set_addr_t A_NTAPS = chan_cfg_pkg::set_addr_t'(`CHAN_RB_NUM_TAPS);
  localparam chan_cfg_pkg::set_addr_t A_PTR   = chan_cfg_pkg::set_addr_t'(`CHAN_RB_COEF_PTR);

  logic                     ce_clk;
  logic                     i_rst_n;
  logic                     i_set_stb;
  chan_cfg_pkg::set_addr_t  i_set_addr;
  chan_cfg_pkg::set_data_t  i_set_data;
  chan_cfg_pkg::set_addr_t  i_rb_addr;
  chan_cfg_pkg::rb_data_t   o_rb_data;
  logic                     i_in_stb;
  chan_data_pkg::sample_t   i_in_data;
  logic                     o_out_stb;
  chan_data_pkg::acc_t      o_out_data;
  chan_data_pkg::branch_t   o_out_chan;
  logic                     o_out_last;

  // Model state indexed [tap][branch] and [branch][age] like the hardware
  chan_data_pkg::coef_t     m_coef [TAPS][16];
  chan_data_pkg::sample_t   m_hist [16][TAPS];
  chan_cfg_pkg::fft_log2_t  m_log2 = 3'd3;
  chan_data_pkg::branch_t   m_br = '0;
  chan_cfg_pkg::pkt_len_t   m_pkt = 16'd16;
  chan_cfg_pkg::pkt_len_t   m_cnt = '0;
  chan_cfg_pkg::coef_addr_t m_ptr = '0;
  chan_data_pkg::acc_t      exp_sum_q [$];
  chan_data_pkg::branch_t   exp_chan_q [$];
  bit                       exp_last_q [$];
  string                    cur_test = "reset";
  int                       cycle_cnt = 0;
  bit                       verdict_shown = 1'b0;

  chan_top dut (.*);

  initial ce_clk = 1'b0;
  always #4 ce_clk = ~ce_clk;

  //////////////////////////////
  // Failure reporting
  //////////////////////////////
  task automatic abort_run(input string why);
    verdict_shown = 1'b1;
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_sum(input chan_data_pkg::acc_t exp, input chan_data_pkg::acc_t act);
    if (exp !== act) abort_run($sformatf("** Error [%s] sum expected %0d actual %0d",
                                         cur_test, exp, act));
  endtask

  task automatic check_chan(input chan_data_pkg::branch_t exp,
                            input chan_data_pkg::branch_t act);
    if (exp !== act) abort_run($sformatf("** Error [%s] chan expected %0d actual %0d",
                                         cur_test, exp, act));
  endtask

  task automatic check_last(input bit exp, input bit act);
    if (exp !== act) abort_run($sformatf("** Error [%s] last expected %0b actual %0b",
                                         cur_test, exp, act));
  endtask

  task automatic check_rb(input chan_cfg_pkg::rb_data_t exp,
                          input chan_cfg_pkg::rb_data_t act);
    if (exp !== act) abort_run($sformatf("** Error [%s] readback expected %h actual %h",
                                         cur_test, exp, act));
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Branch output is the dot product of its taps and its history
  function automatic chan_data_pkg::acc_t branch_output(input chan_data_pkg::branch_t b);
    longint s;
    s = 0;
    for (int k = 0; k < TAPS; k++) begin
      s += longint'(m_coef[k][b]) * longint'(m_hist[b][k]);
    end
    return chan_data_pkg::acc_t'(s);
  endfunction

  task automatic model_sample(input chan_data_pkg::sample_t d);
    chan_data_pkg::branch_t b;
    b = m_br;
    for (int k = TAPS - 1; k > 0; k--) m_hist[b][k] = m_hist[b][k-1];
    m_hist[b][0] = d;
    exp_sum_q.push_back(branch_output(b));
    exp_chan_q.push_back(b);
    // Packet closes on output pkt_len or at once if the size shrank
    if (int'(m_cnt) + 1 >= int'(m_pkt)) begin
      exp_last_q.push_back(1'b1);
      m_cnt = '0;
    end else begin
      exp_last_q.push_back(1'b0);
      m_cnt = m_cnt + 1'b1;
    end
    m_br = (int'(b) == (1 << m_log2) - 1) ? '0 : b + 1'b1;
  endtask

  task automatic model_write(input chan_cfg_pkg::set_addr_t a,
                             input chan_cfg_pkg::set_data_t wd);
    chan_cfg_pkg::fft_log2_t v;
    int tap;
    int br;
    case (a)
      A_FFT: begin
        v = (wd > `CHAN_MAX_LOG2) ? chan_cfg_pkg::fft_log2_t'(`CHAN_MAX_LOG2) : wd[2:0];
        // Commutator restarts only on a real change
        if (v != m_log2) m_br = '0;
        m_log2 = v;
      end
      A_PKT: if (wd[15:0] != 16'd0) m_pkt = wd[15:0];
      A_RLD, A_RLDL: begin
        // Linear address k*M + b
        tap = int'(m_ptr) >> m_log2;
        br  = int'(m_ptr) & ((1 << m_log2) - 1);
        if (tap < TAPS) m_coef[tap][br] = chan_data_pkg::coef_t'(wd[15:0]);
        m_ptr = (a == A_RLDL) ? '0 : m_ptr + 1'b1;
      end
      default: ;
    endcase
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  // One clock of inputs driven 1 ns after the edge
  task automatic drive_cycle(input bit stb, input chan_data_pkg::sample_t d, input bit wr,
                             input chan_cfg_pkg::set_addr_t a,
                             input chan_cfg_pkg::set_data_t wd);
    @(posedge ce_clk);
    #1;
    i_in_stb   = stb;
    i_in_data  = d;
    i_set_stb  = wr;
    i_set_addr = a;
    i_set_data = wd;
    if (stb) model_sample(d);
    if (wr) model_write(a, wd);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic write_reg(input chan_cfg_pkg::set_addr_t a, input chan_cfg_pkg::set_data_t wd);
    drive_cycle(1'b0, '0, 1'b1, a, wd);
  endtask

  // Address goes out in one cycle and the registered word returns a cycle later
  task automatic check_readback(input chan_cfg_pkg::set_addr_t a,
                                input chan_cfg_pkg::rb_data_t exp);
    idle_cycles(1);
    i_rb_addr = a;
    @(posedge ce_clk);
    #1;
    check_rb(exp, o_rb_data);
  endtask

  // Random value with the sign extremes mixed in
  function automatic chan_data_pkg::sample_t pick_value();
    case ($urandom % 8)
      0: return 16'sh8000;
      1: return 16'sh7fff;
      default: return chan_data_pkg::sample_t'($urandom);
    endcase
  endfunction

  task automatic load_random_coefs();
    int n;
    n = TAPS << m_log2;
    for (int a = 0; a < n; a++) begin
      write_reg((a == n - 1) ? A_RLDL : A_RLD, {16'h0000, pick_value()});
    end
    idle_cycles(4);
  endtask

  task automatic stream_random(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      drive_cycle(int'($urandom % 100) >= gap_pct, pick_value(), 1'b0, '0, '0);
    end
    idle_cycles(1);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_sum_q.size() != 0 && n < 64) begin
      @(posedge ce_clk);
      n++;
    end
  endtask

  //////////////////////////////
  // Compare and timeout
  //////////////////////////////
  always @(negedge ce_clk) begin
    if (i_rst_n && o_out_stb) begin
      if (exp_sum_q.size() == 0) begin
        abort_run("An output strobe arrived while no result was expected");
      end else begin
        check_sum(exp_sum_q.pop_front(), o_out_data);
        check_chan(exp_chan_q.pop_front(), o_out_chan);
        check_last(exp_last_q.pop_front(), o_out_last);
      end
    end
  end

  always @(posedge ce_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) abort_run("Timeout, the run did not finish in time");
  end

  final begin
    if (!verdict_shown) begin
      $display("A bound assertion failed and ended the run");
      $display("SOME TESTS FAILED");
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    chan_data_pkg::coef_t c;
    int k;
    void'($urandom(32'hccae_e8ee));
    for (int t = 0; t < TAPS; t++) begin
      for (int b = 0; b < 16; b++) begin
        m_coef[t][b] = '0;
        m_hist[b][t] = '0;
      end
    end
    i_rst_n    = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr  = '0;
    i_in_stb   = 1'b0;
    i_in_data  = '0;
    #1 i_rst_n = 1'b0;
    repeat (10) @(posedge ce_clk);
    #1;
    check_rb('0, o_rb_data);
    i_rst_n = 1'b1;

    cur_test = "reset_readback";
    check_readback(A_FFT, 32'd3);
    check_readback(A_PKT, 32'd16);
    check_readback(A_NTAPS, 32'd32);
    check_readback(A_PTR, 32'd0);
    check_readback(8'd7, `CHAN_RB_BAD);

    cur_test = "register_rules";
    write_reg(A_PKT, 32'd40);
    check_readback(A_PKT, 32'd40);
    write_reg(A_PKT, 32'd0);
    check_readback(A_PKT, 32'd40);
    write_reg(A_FFT, 32'd1);
    check_readback(A_FFT, 32'd1);
    check_readback(A_NTAPS, 32'd8);
    write_reg(A_FFT, 32'd7);
    check_readback(A_FFT, 32'd4);
    check_readback(A_NTAPS, 32'd64);
    write_reg(A_RLD, 32'd11);
    write_reg(A_RLD, 32'd22);
    write_reg(A_RLD, 32'd33);
    check_readback(A_PTR, 32'd3);
    write_reg(A_RLDL, 32'd44);
    check_readback(A_PTR, 32'd0);

    // Distinct taps with odd taps negative so each impulse echoes its branch
    cur_test = "impulse";
    write_reg(A_FFT, 32'd2);
    for (int a = 0; a < 16; a++) begin
      k = a >> 2;
      c = chan_data_pkg::coef_t'(((k + 1) << 8) + (a & 3) + 1);
      if (k % 2 == 1) c = -c;
      write_reg((a == 15) ? A_RLDL : A_RLD, {16'h0000, c});
    end
    idle_cycles(4);
    for (int b = 0; b < 4; b++) begin
      for (int r = 0; r < 4; r++) begin
        for (int i = 0; i < 4; i++) begin
          drive_cycle(1'b1, (r == 0 && i == b) ? 16'sd1 : 16'sd0, 1'b0, '0, '0);
        end
      end
    end
    idle_cycles(1);
    wait_drain();

    cur_test = "stream_m8";
    write_reg(A_FFT, 32'd3);
    load_random_coefs();
    stream_random(400, 0);
    wait_drain();

    cur_test = "stream_m16";
    write_reg(A_FFT, 32'd4);
    load_random_coefs();
    stream_random(400, 0);
    wait_drain();

    cur_test = "packets";
    write_reg(A_PKT, 32'd5);
    stream_random(120, 30);
    wait_drain();

    // Channel count changes in the same cycle as a sample
    cur_test = "m_change";
    for (int i = 0; i < 240; i++) begin
      case (i)
        40:  drive_cycle(1'b1, pick_value(), 1'b1, A_FFT, 32'd2);
        100: drive_cycle(1'b1, pick_value(), 1'b1, A_FFT, 32'd1);
        150: drive_cycle(1'b1, pick_value(), 1'b1, A_FFT, 32'd0);
        190: drive_cycle(1'b1, pick_value(), 1'b1, A_FFT, 32'd4);
        default: drive_cycle(1'b1, pick_value(), 1'b0, '0, '0);
      endcase
    end
    idle_cycles(1);
    wait_drain();
    idle_cycles(8);

    verdict_shown = 1'b1;
    if (exp_sum_q.size() != 0) begin
      $display("Expected results were left in the queue, outputs went missing");
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped with undrained queue");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* chan_top.sv */
/*
 * Channelizer compute engine top level: settings bank,
 * polyphase filter bank and packetizer
 */
`timescale 1ns/1ps

module chan_top (
  input  logic                     ce_clk,
  input  logic                     i_rst_n,
  // Settings bus
  input  logic                     i_set_stb,
  input  chan_cfg_pkg::set_addr_t  i_set_addr,
  input  chan_cfg_pkg::set_data_t  i_set_data,
  // Readback, one cycle behind the address
  input  chan_cfg_pkg::set_addr_t  i_rb_addr,
  output chan_cfg_pkg::rb_data_t   o_rb_data,
  // Sample input
  input  logic                     i_in_stb,
  input  chan_data_pkg::sample_t   i_in_data,
  // Filtered output
  output logic                     o_out_stb,
  output chan_data_pkg::acc_t      o_out_data,
  output chan_data_pkg::branch_t   o_out_chan,
  output logic                     o_out_last
);

  // Filter to packetizer link
  logic                   f_stb;
  chan_data_pkg::acc_t    f_sum;
  chan_data_pkg::branch_t f_branch;

  chan_cfg_if cfg ();

  chan_settings u_settings (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_cfg      (cfg.ctrl)
  );

  chan_pfb_filter u_filter (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_cfg      (cfg.filt),
    .i_in_stb   (i_in_stb),
    .i_in_data  (i_in_data),
    .o_f_stb    (f_stb),
    .o_f_sum    (f_sum),
    .o_f_branch (f_branch)
  );

  chan_packetizer u_packetizer (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_cfg      (cfg.pack),
    .i_f_stb    (f_stb),
    .i_f_sum    (f_sum),
    .i_f_branch (f_branch),
    .o_out_stb  (o_out_stb),
    .o_out_data (o_out_data),
    .o_out_chan (o_out_chan),
    .o_out_last (o_out_last)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the channelizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module chan_tb -f chan.f -o chan_sim

# Output goes to the terminal, grep decides pass or fail
./obj_dir/chan_sim | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

echo "Simulation passed"
